// ==== common/mac_pkg.sv ====
// Shared widths, operand types and timing constants for the UART MAC harness

package mac_pkg;

	// serial data byte
	typedef logic [7:0] byte_t;

	// one MAC operand, bytes are zero-extended into it
	typedef logic [17:0] operand_t;

	// registered product of two operands
	typedef logic [35:0] product_t;

	// running sum, wraps modulo 2**48
	typedef logic [47:0] acc_t;

	// clock cycles per UART bit
	localparam int CLKS_PER_BIT = 16;

	// width of the bit-time counters in rx and tx
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);

	// consecutive equal samples before a switch level counts as settled
	localparam int DEBOUNCE_CYCLES = 32;

	// width of the debounce stability counter
	localparam int DEBOUNCE_CNT_W = $clog2(DEBOUNCE_CYCLES);

	// operand phase of the collector
	typedef enum logic {
		WAIT_A,
		WAIT_B
	} collector_state_t;

endpackage

// ==== mac/mac_operand_collector.sv ====
// Operand collector that pairs received bytes into MAC operands and queues the result byte
`timescale 1ns/1ps

module mac_operand_collector (
	input  logic              CLK,
	input  logic              RESET,
	input  logic              clear,
	input  mac_pkg::byte_t    rx_data,
	input  logic              rx_valid,
	output mac_pkg::operand_t operand_a,
	output mac_pkg::operand_t operand_b,
	output logic              mac_start,
	input  mac_pkg::acc_t     acc,
	input  logic              acc_valid,
	output mac_pkg::byte_t    tx_data,
	output logic              tx_start,
	input  logic              tx_busy
);

	mac_pkg::collector_state_t phase;

	// phase and strobes
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase     <= mac_pkg::WAIT_A;
			mac_start <= 1'b0;
			tx_start  <= 1'b0;
		end else if (clear) begin
			// a held first byte is forgotten here
			phase     <= mac_pkg::WAIT_A;
			mac_start <= 1'b0;
			tx_start  <= 1'b0;
		end else begin
			mac_start <= 1'b0;
			tx_start  <= acc_valid;
			if (rx_valid) begin
				case (phase)
					mac_pkg::WAIT_A: phase <= mac_pkg::WAIT_B;
					mac_pkg::WAIT_B: begin
						phase     <= mac_pkg::WAIT_A;
						mac_start <= 1'b1;
					end
					default: phase <= mac_pkg::WAIT_A;
				endcase
			end
		end
	end

	// operand registers, bytes zero-extended
	always_ff @(posedge CLK) begin
		if (rx_valid) begin
			if (phase == mac_pkg::WAIT_A) begin
				operand_a <= mac_pkg::operand_t'(rx_data);
			end else begin
				operand_b <= mac_pkg::operand_t'(rx_data);
			end
		end
	end

	// only the low accumulator byte goes back on the line
	always_ff @(posedge CLK) begin
		if (acc_valid) begin
			tx_data <= acc[7:0];
		end
	end

	// the serial pair rate leaves the transmitter idle before each result
	assert property (@(posedge CLK) disable iff (RESET) acc_valid |-> !tx_busy);

endmodule

// ==== mac/mac_unit.sv ====
// Two-stage unsigned multiply-accumulate into a 48-bit accumulator with synchronous clear
`timescale 1ns/1ps

module mac_unit (
	input  logic              CLK,
	input  logic              RESET,
	input  logic              clear,
	input  mac_pkg::operand_t operand_a,
	input  mac_pkg::operand_t operand_b,
	input  logic              mac_start,
	output mac_pkg::acc_t     acc,
	output logic              acc_valid
);

	mac_pkg::product_t product_q;
	logic              product_valid;

	// stage 1 product
	always_ff @(posedge CLK) begin
		if (mac_start) begin
			product_q <= mac_pkg::product_t'(operand_a) * mac_pkg::product_t'(operand_b);
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			product_valid <= 1'b0;
		end else if (clear) begin
			product_valid <= 1'b0;
		end else begin
			product_valid <= mac_start;
		end
	end

	// stage 2 accumulate, wraps at 48 bits
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			acc       <= '0;
			acc_valid <= 1'b0;
		end else if (clear) begin
			acc       <= '0;
			acc_valid <= 1'b0;
		end else begin
			acc_valid <= product_valid;
			if (product_valid) begin
				acc <= acc + mac_pkg::acc_t'(product_q);
			end
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the UART MAC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mac_uart \
	-f tb.f \
	--Mdir obj_dir \
	-o tb_mac_uart

./obj_dir/tb_mac_uart > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// ==== src/clear_debouncer.sv ====
// Clear switch debouncer that turns a settled low level on clear_n into a one-cycle strobe
`timescale 1ns/1ps

module clear_debouncer (
	input  logic CLK,
	input  logic RESET,
	input  logic clear_n,
	output logic clear
);

	logic                                sync_q1;
	logic                                sync_q2;
	logic                                level;
	logic [mac_pkg::DEBOUNCE_CNT_W-1:0] stable_cnt;

	// two-flop synchronizer, the switch idles high
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			sync_q1 <= 1'b1;
			sync_q2 <= 1'b1;
		end else begin
			sync_q1 <= clear_n;
			sync_q2 <= sync_q1;
		end
	end

	// count samples that disagree with the settled level
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			level      <= 1'b1;
			stable_cnt <= '0;
			clear      <= 1'b0;
		end else begin
			clear <= 1'b0;
			if (sync_q2 == level) begin
				stable_cnt <= '0;
			end else if (stable_cnt == mac_pkg::DEBOUNCE_CYCLES - 1) begin
				stable_cnt <= '0;
				level      <= sync_q2;
				// strobe only on the falling edge of the settled level
				clear      <= level & ~sync_q2;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

	// re-arming needs a full settled high period, so strobes never touch
	assert property (@(posedge CLK) disable iff (RESET) clear |=> !clear);

endmodule

// ==== src/mac_uart_top.sv ====
// Top level of the UART MAC harness joining receiver, collector, MAC, transmitter and clear
`timescale 1ns/1ps

module mac_uart_top (
	input  logic CLK,
	input  logic RESET,
	input  logic rx,
	input  logic clear_n,
	output logic tx
);

	mac_pkg::byte_t    rx_data;
	logic              rx_valid;
	mac_pkg::operand_t operand_a;
	mac_pkg::operand_t operand_b;
	logic              mac_start;
	mac_pkg::acc_t     acc;
	logic              acc_valid;
	mac_pkg::byte_t    tx_data;
	logic              tx_start;
	logic              tx_busy;
	logic              clear;

	clear_debouncer u_clear (
		.CLK     (CLK),
		.RESET   (RESET),
		.clear_n (clear_n),
		.clear   (clear)
	);

	uart_rx u_rx (
		.CLK      (CLK),
		.RESET    (RESET),
		.rx       (rx),
		.rx_data  (rx_data),
		.rx_valid (rx_valid)
	);

	mac_operand_collector u_collector (
		.CLK       (CLK),
		.RESET     (RESET),
		.clear     (clear),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.mac_start (mac_start),
		.acc       (acc),
		.acc_valid (acc_valid),
		.tx_data   (tx_data),
		.tx_start  (tx_start),
		.tx_busy   (tx_busy)
	);

	mac_unit u_mac (
		.CLK       (CLK),
		.RESET     (RESET),
		.clear     (clear),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.mac_start (mac_start),
		.acc       (acc),
		.acc_valid (acc_valid)
	);

	uart_tx u_tx (
		.CLK      (CLK),
		.RESET    (RESET),
		.tx_data  (tx_data),
		.tx_start (tx_start),
		.tx       (tx),
		.tx_busy  (tx_busy)
	);

endmodule

// ==== tb.f ====
common/mac_pkg.sv
src/clear_debouncer.sv
uart/uart_rx.sv
uart/uart_tx.sv
mac/mac_unit.sv
mac/mac_operand_collector.sv
src/mac_uart_top.sv
testbench/tb_mac_uart.sv

// ==== testbench/tb_mac_uart.sv ====
// Testbench for the UART MAC harness that drives serial pairs and checks each returned byte
`timescale 1ns/1ps

module tb_mac_uart;

	localparam int SEED = 30492;
	localparam int NUM_RANDOM = 20;
	localparam int BIT_CLKS = mac_pkg::CLKS_PER_BIT;
	localparam int GLITCH_CYCLES = 10;
	// rx frames of the directed, random, clear and glitch tests
	localparam int TOTAL_FRAMES = 4 + 2 * NUM_RANDOM + 3 + 4;
	localparam int WATCHDOG_CYCLES = (TOTAL_FRAMES * 12 + 150) * BIT_CLKS;
	// a result frame ends well within this after its pair was sent
	localparam int IDLE_TIMEOUT_CYCLES = 16 * BIT_CLKS;

	logic           CLK;
	logic           RESET;
	logic           rx;
	logic           clear_n;
	logic           tx;
	logic [47:0]    acc_model;
	mac_pkg::byte_t exp_q[$];
	string          name_q[$];
	string          test_name;
	int             pairs_sent;
	int             frames_seen;
	logic           stim_started;
	mac_pkg::byte_t dec_byte;
	mac_pkg::byte_t dec_exp;
	string          dec_name;
	logic           dec_strobe;

	mac_uart_top i_mac_uart_top (
		.CLK     (CLK),
		.RESET   (RESET),
		.rx      (rx),
		.clear_n (clear_n),
		.tx      (tx)
	);

	always #5 CLK = ~CLK;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	// one bit time on rx, changed just after the rising edge
	task automatic send_bit(input logic value);
		@(posedge CLK);
		#1;
		rx = value;
		repeat (BIT_CLKS - 1) @(posedge CLK);
	endtask

	// start, 8 data bits lsb first, stop, then 2 idle bits
	task automatic send_byte(input mac_pkg::byte_t value);
		int i;
		send_bit(1'b0);
		for (i = 0; i < 8; i++) begin
			send_bit(value[i]);
		end
		send_bit(1'b1);
		send_bit(1'b1);
		send_bit(1'b1);
	endtask

	// reference model keeps the full 48-bit running sum
	task automatic send_pair(input mac_pkg::byte_t a, input mac_pkg::byte_t b);
		send_byte(a);
		send_byte(b);
		acc_model = acc_model + 48'(a) * 48'(b);
		exp_q.push_back(acc_model[7:0]);
		name_q.push_back(test_name);
		pairs_sent++;
	endtask

	// a frame that never comes leaves its pair in the queue and shows in the count
	task automatic wait_idle();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < IDLE_TIMEOUT_CYCLES) begin
			@(posedge CLK);
			n++;
		end
		repeat (2 * BIT_CLKS) @(posedge CLK);
	endtask

	task automatic check_frames();
		assert (frames_seen == pairs_sent)
		else fail_now($sformatf("MISMATCH %s frame count expected %0d actual %0d",
			test_name, pairs_sent, frames_seen));
	endtask

	// long enough low level for the debouncer, then a settled high to re-arm
	task automatic apply_clear();
		wait_idle();
		check_frames();
		@(posedge CLK);
		#1;
		clear_n = 1'b0;
		repeat (mac_pkg::DEBOUNCE_CYCLES + 8) @(posedge CLK);
		#1;
		clear_n = 1'b1;
		repeat (mac_pkg::DEBOUNCE_CYCLES + 8) @(posedge CLK);
		acc_model = '0;
		pairs_sent = 0;
		frames_seen = 0;
	endtask

	task automatic glitch_clear(input int cycles);
		@(posedge CLK);
		#1;
		clear_n = 1'b0;
		repeat (cycles) @(posedge CLK);
		#1;
		clear_n = 1'b1;
	endtask

	// tx must stay idle until the first byte goes out
	assert property (@(posedge CLK) disable iff (RESET) !stim_started |-> tx)
	else fail_now("start bit seen on tx before any stimulus");

	assert property (@(posedge CLK) disable iff (RESET) dec_strobe |-> dec_byte == dec_exp)
	else fail_now($sformatf("MISMATCH %s expected 0x%02h actual 0x%02h",
		dec_name, dec_exp, dec_byte));

	// samples tx on falling clock edges, half a bit into each bit
	initial begin : tx_decoder
		mac_pkg::byte_t data;
		logic           stop_bit;
		int             i;
		forever begin
			@(negedge tx);
			repeat (BIT_CLKS / 2) @(negedge CLK);
			if (tx === 1'b0) begin
				for (i = 0; i < 8; i++) begin
					repeat (BIT_CLKS) @(negedge CLK);
					data[i] = tx;
				end
				repeat (BIT_CLKS) @(negedge CLK);
				stop_bit = tx;
				if (stop_bit !== 1'b1) begin
					fail_now("decoded tx frame has a low stop bit");
				end else if (exp_q.size() == 0) begin
					fail_now("tx frame arrived with no pair pending");
				end else begin
					dec_exp = exp_q.pop_front();
					dec_name = name_q.pop_front();
					dec_byte = data;
					frames_seen++;
					dec_strobe = 1'b1;
					@(negedge CLK);
					dec_strobe = 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		fail_now("watchdog timeout, the run did not finish in time");
	end

	initial begin : stimulus
		mac_pkg::byte_t a;
		mac_pkg::byte_t b;
		int             i;
		CLK = 1'b0;
		RESET = 1'b1;
		rx = 1'b1;
		clear_n = 1'b1;
		acc_model = '0;
		pairs_sent = 0;
		frames_seen = 0;
		stim_started = 1'b0;
		dec_strobe = 1'b0;
		dec_byte = '0;
		dec_exp = '0;
		test_name = "reset_idle";
		void'($urandom(SEED));
		repeat (2) @(posedge CLK);
		#1;
		RESET = 1'b0;

		// quiet line after reset
		repeat (4 * BIT_CLKS) @(posedge CLK);
		#1;
		stim_started = 1'b1;

		test_name = "single_pair";
		send_pair(8'd10, 8'd5);
		apply_clear();
		send_pair(8'd255, 8'd255);

		test_name = "accumulate";
		for (i = 0; i < NUM_RANDOM; i++) begin
			a = mac_pkg::byte_t'($urandom % 256);
			b = mac_pkg::byte_t'($urandom % 256);
			// corner values
			if (i == 0) a = 8'd0;
			if (i == 1) b = 8'd255;
			if (i == 2) begin
				a = 8'd255;
				b = 8'd255;
			end
			send_pair(a, b);
		end

		// a lone first byte is pending when the clear lands
		test_name = "clear_mid_pair";
		wait_idle();
		send_byte(mac_pkg::byte_t'($urandom % 256));
		apply_clear();
		send_pair(mac_pkg::byte_t'($urandom % 256), mac_pkg::byte_t'($urandom % 256));

		test_name = "glitch_reject";
		send_pair(mac_pkg::byte_t'($urandom % 256), mac_pkg::byte_t'($urandom % 256));
		glitch_clear(GLITCH_CYCLES);
		repeat (mac_pkg::DEBOUNCE_CYCLES + 8) @(posedge CLK);
		send_pair(mac_pkg::byte_t'($urandom % 256), mac_pkg::byte_t'($urandom % 256));

		test_name = "frame_count";
		wait_idle();
		check_frames();
		$display("all tests passed");
		$finish;
	end

endmodule

// ==== uart/uart_rx.sv ====
// UART receiver for 8N1 frames that strobes each byte at the middle of its stop bit
`timescale 1ns/1ps

module uart_rx (
	input  logic           CLK,
	input  logic           RESET,
	input  logic           rx,
	output mac_pkg::byte_t rx_data,
	output logic           rx_valid
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t                      state;
	logic [mac_pkg::BIT_CNT_W-1:0] clk_cnt;
	logic [2:0]                     bit_idx;
	mac_pkg::byte_t                 shift_q;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rx) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					// look at the start bit again half a bit later
					if (clk_cnt == mac_pkg::CLKS_PER_BIT / 2 - 1) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (clk_cnt == mac_pkg::CLKS_PER_BIT - 1) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (clk_cnt == mac_pkg::CLKS_PER_BIT - 1) begin
						clk_cnt <= '0;
						// a low stop bit drops the byte
						rx_valid <= rx;
						state    <= RX_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge CLK) begin
		if (state == RX_DATA && clk_cnt == mac_pkg::CLKS_PER_BIT - 1) begin
			shift_q <= {rx, shift_q[7:1]};
		end
	end

	assign rx_data = shift_q;

endmodule

// ==== uart/uart_tx.sv ====
// UART transmitter that sends one 8N1 frame per start strobe and flags busy meanwhile
`timescale 1ns/1ps

module uart_tx (
	input  logic           CLK,
	input  logic           RESET,
	input  mac_pkg::byte_t tx_data,
	input  logic           tx_start,
	output logic           tx,
	output logic           tx_busy
);

	logic [mac_pkg::BIT_CNT_W-1:0] clk_cnt;
	logic [3:0]                     bit_idx;
	logic [8:0]                     frame_q;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			tx      <= 1'b1;
			tx_busy <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				// start bit goes out right away
				tx      <= 1'b0;
				tx_busy <= 1'b1;
				clk_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (clk_cnt == mac_pkg::CLKS_PER_BIT - 1) begin
			clk_cnt <= '0;
			if (bit_idx == 4'd9) begin
				// stop bit has been held for a full bit time
				tx_busy <= 1'b0;
			end else begin
				tx      <= frame_q[0];
				bit_idx <= bit_idx + 1'b1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// data lsb first, then the stop bit shifted in from the top
	always_ff @(posedge CLK) begin
		if (!tx_busy && tx_start) begin
			frame_q <= {1'b1, tx_data};
		end else if (tx_busy && clk_cnt == mac_pkg::CLKS_PER_BIT - 1) begin
			frame_q <= {1'b1, frame_q[8:1]};
		end
	end

	// a start while busy would be lost, there is no queue
	assert property (@(posedge CLK) disable iff (RESET) tx_start |-> !tx_busy);

endmodule
